// ==== common/lsq_pkg.sv ====
`default_nettype none

package lsq_pkg;

  // store request fields
  typedef logic [15:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [1:0]  size_t;

  // size codes, code 3 is not used
  localparam size_t SZ_BYTE = 2'd0;
  localparam size_t SZ_HALF = 2'd1;
  localparam size_t SZ_WORD = 2'd2;

  // one cache row is 8 banks of 4 bytes
  localparam int N_BANKS = 8;

  // bank number, addr[4:2]
  typedef logic [2:0] bank_t;

  // byte offset in a bank, addr[1:0]
  typedef logic [1:0] low_t;

  typedef logic [3:0] ben_t;
  typedef logic [N_BANKS-1:0] bank_mask_t;

  // hold request sources
  localparam int HOLD_W = 4;

endpackage

`default_nettype wire

// ==== src/store_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer #(
  parameter int DEPTH = 8
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           push,
  input  lsq_pkg::addr_t push_addr,
  input  lsq_pkg::size_t push_size,
  input  lsq_pkg::word_t push_data,
  input  logic           pop0,
  input  logic           pop1,
  output logic           full,
  output logic           head0_valid,
  output lsq_pkg::addr_t head0_addr,
  output lsq_pkg::size_t head0_size,
  output lsq_pkg::word_t head0_data,
  output logic           head1_valid,
  output lsq_pkg::addr_t head1_addr,
  output lsq_pkg::size_t head1_size,
  output lsq_pkg::word_t head1_data
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

  lsq_pkg::addr_t addr_mem [DEPTH];
  lsq_pkg::size_t size_mem [DEPTH];
  lsq_pkg::word_t data_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_1;
  logic [PTR_W:0]   count;
  logic [PTR_W:0]   count_next;
  logic [1:0]       pop_cnt;

  assign rd_ptr_1 = rd_ptr + 1'b1;
  assign pop_cnt  = {1'b0, pop0} + {1'b0, pop1};

  always_comb begin
    count_next = count;
    if (push) begin
      count_next = count_next + 1'b1;
    end
    count_next = count_next - {{(PTR_W - 1){1'b0}}, pop_cnt};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr + {{(PTR_W - 2){1'b0}}, pop_cnt};
      count  <= count_next;
      full   <= (count_next == FULL_COUNT);
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr] <= push_addr;
      size_mem[wr_ptr] <= push_size;
      data_mem[wr_ptr] <= push_data;
    end
  end

  // two oldest entries
  assign head0_valid = (count != '0);
  assign head0_addr  = addr_mem[rd_ptr];
  assign head0_size  = size_mem[rd_ptr];
  assign head0_data  = data_mem[rd_ptr];

  assign head1_valid = (count > 1);
  assign head1_addr  = addr_mem[rd_ptr_1];
  assign head1_size  = size_mem[rd_ptr_1];
  assign head1_data  = data_mem[rd_ptr_1];

  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (reset) push |-> !full
  );

  a_no_pop_when_absent: assert property (
    @(posedge clk) disable iff (reset)
      (pop0 |-> head0_valid) and (pop1 |-> head1_valid)
  );

endmodule

`default_nettype wire

// ==== src/store_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_issue (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [lsq_pkg::HOLD_W-1:0] hold,
  input  logic                       dc_busy,
  input  logic                       head0_valid,
  input  lsq_pkg::addr_t             head0_addr,
  input  lsq_pkg::size_t             head0_size,
  input  lsq_pkg::word_t             head0_data,
  input  logic                       head1_valid,
  input  lsq_pkg::addr_t             head1_addr,
  input  lsq_pkg::size_t             head1_size,
  input  lsq_pkg::word_t             head1_data,
  output logic                       pop0,
  output logic                       pop1,
  output logic                       wr0_en,
  output logic                       wr1_en,
  output lsq_pkg::addr_t             wr0_addr,
  output lsq_pkg::addr_t             wr1_addr,
  output lsq_pkg::size_t             wr0_size,
  output lsq_pkg::size_t             wr1_size,
  output lsq_pkg::word_t             wr0_data,
  output lsq_pkg::word_t             wr1_data
);

  // banks touched by a store within the row
  function automatic lsq_pkg::bank_mask_t bank_mask(input lsq_pkg::addr_t addr,
                                                    input lsq_pkg::size_t size);
    logic [4:0] last_pos;
    lsq_pkg::bank_mask_t mask;
    case (size)
      lsq_pkg::SZ_BYTE: last_pos = addr[4:0];
      lsq_pkg::SZ_HALF: last_pos = addr[4:0] + 5'd1;
      default:          last_pos = addr[4:0] + 5'd3;
    endcase
    mask = '0;
    mask[addr[4:2]] = 1'b1;
    mask[last_pos[4:2]] = 1'b1;
    return mask;
  endfunction

  logic                busy_q;
  logic                stall;
  logic                fire0;
  logic                fire1;
  lsq_pkg::bank_mask_t mask0;
  lsq_pkg::bank_mask_t mask1;

  assign mask0 = bank_mask(head0_addr, head0_size);
  assign mask1 = bank_mask(head1_addr, head1_size);

  assign stall = (|hold) | busy_q;
  assign fire0 = head0_valid & ~stall;
  // second store only rides along on disjoint banks
  assign fire1 = fire0 & head1_valid & ((mask0 & mask1) == '0);

  assign pop0 = fire0;
  assign pop1 = fire1;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      wr0_en <= 1'b0;
      wr1_en <= 1'b0;
    end else begin
      busy_q <= dc_busy;
      wr0_en <= fire0;
      wr1_en <= fire1;
    end
  end

  always_ff @(posedge clk) begin
    if (fire0) begin
      wr0_addr <= head0_addr;
      wr0_size <= head0_size;
      wr0_data <= head0_data;
    end
    if (fire1) begin
      wr1_addr <= head1_addr;
      wr1_size <= head1_size;
      wr1_data <= head1_data;
    end
  end

  a_head1_behind_head0: assert property (
    @(posedge clk) disable iff (reset) head1_valid |-> head0_valid
  );

endmodule

`default_nettype wire

// ==== src/store_lane_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_lane_format (
  input  lsq_pkg::addr_t addr,
  input  lsq_pkg::size_t size,
  input  lsq_pkg::word_t data,
  output lsq_pkg::bank_t bgn_bank,
  output lsq_pkg::bank_t end_bank,
  output lsq_pkg::ben_t  bgn_ben,
  output lsq_pkg::ben_t  end_ben,
  output lsq_pkg::word_t lane_data
);

  lsq_pkg::low_t  low;
  lsq_pkg::ben_t  size_ben;
  logic [1:0]     last_off;
  logic [4:0]     end_pos;
  logic [7:0]     span;
  lsq_pkg::word_t byte_mask;
  lsq_pkg::word_t masked;
  logic [63:0]    rot;

  assign low      = addr[1:0];
  assign bgn_bank = addr[4:2];

  always_comb begin
    case (size)
      lsq_pkg::SZ_BYTE: size_ben = 4'b0001;
      lsq_pkg::SZ_HALF: size_ben = 4'b0011;
      lsq_pkg::SZ_WORD: size_ben = 4'b1111;
      default:          size_ben = 4'b1111;
    endcase
  end

  // last byte offset from the start
  assign last_off = {size_ben[3], size_ben[1]};

  // wraps inside the 32 byte row
  assign end_pos  = {bgn_bank, low} + {3'b000, last_off};
  assign end_bank = end_pos[4:2];

  // bytes over two adjacent banks
  assign span    = {4'b0000, size_ben} << low;
  assign bgn_ben = span[3:0];
  assign end_ben = (span[7:4] == 4'b0000) ? span[3:0] : span[7:4];

  assign byte_mask = {{8{size_ben[3]}}, {8{size_ben[2]}},
                      {8{size_ben[1]}}, {8{size_ben[0]}}};
  assign masked    = data & byte_mask;

  // rotate left by low bytes
  assign rot       = {masked, masked} << {low, 3'b000};
  assign lane_data = rot[63:32];

endmodule

`default_nettype wire

// ==== src/store_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_drain #(
  parameter int DEPTH = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       push,
  input  lsq_pkg::addr_t             push_addr,
  input  lsq_pkg::size_t             push_size,
  input  lsq_pkg::word_t             push_data,
  input  logic [lsq_pkg::HOLD_W-1:0] hold,
  input  logic                       dc_busy,
  output logic                       full,
  output logic                       wr0_en,
  output lsq_pkg::addr_t             wr0_addr,
  output lsq_pkg::bank_t             wr0_bgn_bank,
  output lsq_pkg::bank_t             wr0_end_bank,
  output lsq_pkg::ben_t              wr0_bgn_ben,
  output lsq_pkg::ben_t              wr0_end_ben,
  output lsq_pkg::word_t             wr0_data,
  output logic                       wr1_en,
  output lsq_pkg::addr_t             wr1_addr,
  output lsq_pkg::bank_t             wr1_bgn_bank,
  output lsq_pkg::bank_t             wr1_end_bank,
  output lsq_pkg::ben_t              wr1_bgn_ben,
  output lsq_pkg::ben_t              wr1_end_ben,
  output lsq_pkg::word_t             wr1_data
);

  logic           head0_valid;
  lsq_pkg::addr_t head0_addr;
  lsq_pkg::size_t head0_size;
  lsq_pkg::word_t head0_data;
  logic           head1_valid;
  lsq_pkg::addr_t head1_addr;
  lsq_pkg::size_t head1_size;
  lsq_pkg::word_t head1_data;
  logic           pop0;
  logic           pop1;

  // registered store fields before lane formatting
  lsq_pkg::size_t wr0_size;
  lsq_pkg::size_t wr1_size;
  lsq_pkg::word_t wr0_store_data;
  lsq_pkg::word_t wr1_store_data;

  store_buffer #(
    .DEPTH(DEPTH)
  ) u_buffer (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_addr  (push_addr),
    .push_size  (push_size),
    .push_data  (push_data),
    .pop0       (pop0),
    .pop1       (pop1),
    .full       (full),
    .head0_valid(head0_valid),
    .head0_addr (head0_addr),
    .head0_size (head0_size),
    .head0_data (head0_data),
    .head1_valid(head1_valid),
    .head1_addr (head1_addr),
    .head1_size (head1_size),
    .head1_data (head1_data)
  );

  store_issue u_issue (
    .clk        (clk),
    .reset      (reset),
    .hold       (hold),
    .dc_busy    (dc_busy),
    .head0_valid(head0_valid),
    .head0_addr (head0_addr),
    .head0_size (head0_size),
    .head0_data (head0_data),
    .head1_valid(head1_valid),
    .head1_addr (head1_addr),
    .head1_size (head1_size),
    .head1_data (head1_data),
    .pop0       (pop0),
    .pop1       (pop1),
    .wr0_en     (wr0_en),
    .wr1_en     (wr1_en),
    .wr0_addr   (wr0_addr),
    .wr1_addr   (wr1_addr),
    .wr0_size   (wr0_size),
    .wr1_size   (wr1_size),
    .wr0_data   (wr0_store_data),
    .wr1_data   (wr1_store_data)
  );

  store_lane_format u_lane0 (
    .addr     (wr0_addr),
    .size     (wr0_size),
    .data     (wr0_store_data),
    .bgn_bank (wr0_bgn_bank),
    .end_bank (wr0_end_bank),
    .bgn_ben  (wr0_bgn_ben),
    .end_ben  (wr0_end_ben),
    .lane_data(wr0_data)
  );

  store_lane_format u_lane1 (
    .addr     (wr1_addr),
    .size     (wr1_size),
    .data     (wr1_store_data),
    .bgn_bank (wr1_bgn_bank),
    .end_bank (wr1_end_bank),
    .bgn_ben  (wr1_bgn_ben),
    .end_ben  (wr1_end_ben),
    .lane_data(wr1_data)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/store_model.svh ====
`ifndef STORE_MODEL_SVH
`define STORE_MODEL_SVH

typedef struct packed {
  lsq_pkg::addr_t addr;
  lsq_pkg::size_t size;
  lsq_pkg::word_t data;
} store_t;

// stores taken by the buffer and not yet written out, oldest first
store_t exp_q[$];

function automatic int size_bytes(input lsq_pkg::size_t size);
  case (size)
    lsq_pkg::SZ_BYTE: return 1;
    lsq_pkg::SZ_HALF: return 2;
    default:          return 4;
  endcase
endfunction

// row position of byte k, wraps in the 32 byte row
function automatic logic [4:0] byte_pos(input store_t st, input int k);
  return st.addr[4:0] + 5'(k);
endfunction

function automatic lsq_pkg::bank_mask_t banks_of(input store_t st);
  lsq_pkg::bank_mask_t mask;
  logic [4:0]          pos;
  mask = '0;
  for (int k = 0; k < size_bytes(st.size); k++) begin
    pos = byte_pos(st, k);
    mask[pos[4:2]] = 1'b1;
  end
  return mask;
endfunction

task automatic expected_lanes(input store_t st, output lsq_pkg::bank_t bgn_bank,
                              output lsq_pkg::bank_t end_bank, output lsq_pkg::ben_t bgn_ben,
                              output lsq_pkg::ben_t end_ben, output lsq_pkg::word_t lane);
  int         n;
  int         off;
  logic [4:0] last;
  n = size_bytes(st.size);
  off = st.addr[1:0];
  last = byte_pos(st, n - 1);
  bgn_bank = st.addr[4:2];
  end_bank = last[4:2];
  bgn_ben = '0;
  end_ben = '0;
  lane = '0;
  for (int k = 0; k < n; k++) begin
    if (off + k < 4) begin
      bgn_ben[off + k] = 1'b1;
    end else begin
      end_ben[off + k - 4] = 1'b1;
    end
    lane[((off + k) % 4) * 8 +: 8] = st.data[k * 8 +: 8];
  end
  if (end_bank == bgn_bank) begin
    end_ben = bgn_ben;
  end
endtask

task automatic check_port(input int port, input lsq_pkg::addr_t addr,
                          input lsq_pkg::bank_t bgn_bank, input lsq_pkg::bank_t end_bank,
                          input lsq_pkg::ben_t bgn_ben, input lsq_pkg::ben_t end_ben,
                          input lsq_pkg::word_t lane);
  store_t         st;
  lsq_pkg::bank_t e_bgn_bank;
  lsq_pkg::bank_t e_end_bank;
  lsq_pkg::ben_t  e_bgn_ben;
  lsq_pkg::ben_t  e_end_ben;
  lsq_pkg::word_t e_lane;
  assert (exp_q.size() > 0) else begin
    other_errors++;
    $display("ERROR at %0t: port %0d wrote with no store pending", $time, port);
  end
  if (exp_q.size() > 0) begin
    st = exp_q.pop_front();
    expected_lanes(st, e_bgn_bank, e_end_bank, e_bgn_ben, e_end_ben, e_lane);
    assert ({addr, bgn_bank, end_bank, bgn_ben, end_ben, lane} ==
            {st.addr, e_bgn_bank, e_end_bank, e_bgn_ben, e_end_ben, e_lane}) else begin
      mismatches++;
      $display("MISMATCH at %0t: port %0d addr %h banks %0d/%0d ben %b/%b data %h",
               $time, port, addr, bgn_bank, end_bank, bgn_ben, end_ben, lane);
      $display("  expected addr %h banks %0d/%0d ben %b/%b data %h",
               st.addr, e_bgn_bank, e_end_bank, e_bgn_ben, e_end_ben, e_lane);
    end
  end
endtask

`endif

// ==== bench/store_drain_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_drain_tb;

  localparam int DEPTH = 8;

  typedef struct packed {
    logic                       push;
    lsq_pkg::addr_t             addr;
    lsq_pkg::size_t             size;
    lsq_pkg::word_t             data;
    logic [lsq_pkg::HOLD_W-1:0] hold;
    logic                       busy;
  } row_t;

  logic                       clk;
  logic                       reset;
  logic                       push;
  lsq_pkg::addr_t             push_addr;
  lsq_pkg::size_t             push_size;
  lsq_pkg::word_t             push_data;
  logic [lsq_pkg::HOLD_W-1:0] hold;
  logic                       dc_busy;
  logic                       full;
  logic                       wr0_en, wr1_en;
  lsq_pkg::addr_t             wr0_addr, wr1_addr;
  lsq_pkg::bank_t             wr0_bgn_bank, wr0_end_bank, wr1_bgn_bank, wr1_end_bank;
  lsq_pkg::ben_t              wr0_bgn_ben, wr0_end_ben, wr1_bgn_ben, wr1_end_ben;
  lsq_pkg::word_t             wr0_data, wr1_data;

  int          mismatches;
  int          other_errors;
  row_t        rows[$];
  logic        rows_ready;
  logic [31:0] lfsr;
  logic        pred0;
  logic        pred1;
  logic        busy_prev;
  logic        full_seen;

  `include "store_model.svh"

  tb_clock u_clock (
    .clk  (clk),
    .reset(reset)
  );

  store_drain #(
    .DEPTH(DEPTH)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .push        (push),
    .push_addr   (push_addr),
    .push_size   (push_size),
    .push_data   (push_data),
    .hold        (hold),
    .dc_busy     (dc_busy),
    .full        (full),
    .wr0_en      (wr0_en),
    .wr0_addr    (wr0_addr),
    .wr0_bgn_bank(wr0_bgn_bank),
    .wr0_end_bank(wr0_end_bank),
    .wr0_bgn_ben (wr0_bgn_ben),
    .wr0_end_ben (wr0_end_ben),
    .wr0_data    (wr0_data),
    .wr1_en      (wr1_en),
    .wr1_addr    (wr1_addr),
    .wr1_bgn_bank(wr1_bgn_bank),
    .wr1_end_bank(wr1_end_bank),
    .wr1_bgn_ben (wr1_bgn_ben),
    .wr1_end_ben (wr1_end_ben),
    .wr1_data    (wr1_data)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  task automatic add_row(input logic p, input lsq_pkg::addr_t a, input lsq_pkg::size_t s,
                         input lsq_pkg::word_t d, input logic [lsq_pkg::HOLD_W-1:0] h,
                         input logic b);
    rows.push_back({p, a, s, d, h, b});
  endtask

  task automatic add_idle(input int n, input logic [lsq_pkg::HOLD_W-1:0] h);
    for (int i = 0; i < n; i++) begin
      add_row(1'b0, '0, lsq_pkg::SZ_BYTE, '0, h, 1'b0);
    end
  endtask

  task automatic build_table();
    logic [31:0] r_push;
    logic [31:0] r_addr;
    logic [31:0] r_size;
    logic [31:0] r_data;
    logic [31:0] r_pick;
    logic [31:0] r_hold;
    logic [31:0] r_busy;
    // every size at every row offset, wrapping stores included
    for (int sz = 0; sz < 3; sz++) begin
      for (int a = 0; a < 32; a++) begin
        r_data = rand_bits(32);
        add_row(1'b1, lsq_pkg::addr_t'(16'h1200 + a), lsq_pkg::size_t'(sz), r_data, '0, 1'b0);
      end
    end
    add_idle(6, '0);
    // disjoint pair waits behind hold, banks 0 and 1
    add_row(1'b1, 16'h0040, lsq_pkg::SZ_WORD, 32'h1122_3344, 4'b0001, 1'b0);
    add_row(1'b1, 16'h0046, lsq_pkg::SZ_HALF, 32'h0000_5566, 4'b0001, 1'b0);
    add_idle(6, '0);
    // overlapping pair, both touch bank 1
    add_row(1'b1, 16'h0044, lsq_pkg::SZ_WORD, 32'h99aa_bbcc, 4'b0100, 1'b0);
    add_row(1'b1, 16'h0047, lsq_pkg::SZ_HALF, 32'h0000_ddee, 4'b0100, 1'b0);
    add_idle(6, '0);
    for (int i = 0; i < 6; i++) begin
      add_row(1'b1, lsq_pkg::addr_t'(16'h0080 + 3 * i), lsq_pkg::SZ_HALF, 32'h0000_a5a5 + i,
              '0, i < 3);
    end
    add_idle(6, '0);
    // fill the buffer while held
    for (int i = 0; i < DEPTH; i++) begin
      add_row(1'b1, lsq_pkg::addr_t'(16'h0100 + 4 * i), lsq_pkg::SZ_WORD, 32'hf00d_0000 + i,
              4'b1000, 1'b0);
    end
    add_idle(3, 4'b1000);
    add_idle(DEPTH, '0);
    for (int i = 0; i < 120; i++) begin
      r_push = rand_bits(1);
      r_addr = rand_bits(16);
      r_size = rand_bits(2) % 3;
      r_data = rand_bits(32);
      r_pick = rand_bits(3);
      r_hold = rand_bits(4);
      r_busy = rand_bits(3);
      add_row(r_push[0], r_addr[15:0], r_size[1:0], r_data,
              (r_pick == 0) ? r_hold[3:0] : 4'b0000, r_busy == 0);
    end
    add_idle(2 * DEPTH + 6, '0);
  endtask

  task automatic apply_row(input row_t r);
    @(posedge clk);
    // the model already counts the store in flight
    while (r.push && exp_q.size() >= DEPTH) begin
      push <= 1'b0;
      hold <= '0;
      dc_busy <= 1'b0;
      @(posedge clk);
    end
    push <= r.push;
    push_addr <= r.addr;
    push_size <= r.size;
    push_data <= r.data;
    hold <= r.hold;
    dc_busy <= r.busy;
  endtask

  always @(negedge clk) begin
    if (reset) begin
      pred0 = 1'b0;
      pred1 = 1'b0;
      busy_prev = 1'b0;
    end else begin
      assert (wr0_en == pred0 && wr1_en == pred1) else begin
        mismatches++;
        $display("MISMATCH at %0t: enables wr1/wr0 %b%b, expected %b%b",
                 $time, wr1_en, wr0_en, pred1, pred0);
      end
      if (wr0_en) begin
        check_port(0, wr0_addr, wr0_bgn_bank, wr0_end_bank, wr0_bgn_ben, wr0_end_ben, wr0_data);
      end
      if (wr1_en) begin
        check_port(1, wr1_addr, wr1_bgn_bank, wr1_end_bank, wr1_bgn_ben, wr1_end_ben, wr1_data);
      end
      assert (!(wr0_en && wr1_en) ||
              (wr0_bgn_bank != wr1_bgn_bank && wr0_bgn_bank != wr1_end_bank &&
               wr0_end_bank != wr1_bgn_bank && wr0_end_bank != wr1_end_bank)) else begin
        other_errors++;
        $display("ERROR at %0t: both ports wrote to the same bank", $time);
      end
      assert (full == (exp_q.size() == DEPTH)) else begin
        mismatches++;
        $display("MISMATCH at %0t: full %b with %0d stores buffered", $time, full, exp_q.size());
      end
      if (full) begin
        full_seen = 1'b1;
      end
      // decision of this cycle, seen after the next edge
      pred0 = exp_q.size() > 0 && hold == '0 && !busy_prev;
      pred1 = pred0 && exp_q.size() > 1 && (banks_of(exp_q[0]) & banks_of(exp_q[1])) == '0;
      busy_prev = dc_busy;
      if (push) begin
        exp_q.push_back({push_addr, push_size, push_data});
      end
    end
  end

  initial begin
    wait (rows_ready === 1'b1);
    repeat (rows.size() * 4 + 100) @(posedge clk);
    $display("TIMEOUT: the stimulus table did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    push = 1'b0;
    push_addr = '0;
    push_size = lsq_pkg::SZ_BYTE;
    push_data = '0;
    hold = '0;
    dc_busy = 1'b0;
    mismatches = 0;
    other_errors = 0;
    full_seen = 1'b0;
    rows_ready = 1'b0;
    lfsr = 32'hd177;
    build_table();
    rows_ready = 1'b1;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    repeat (3) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("ERROR: %0d stores were never written out", exp_q.size());
    end
    assert (full_seen) else begin
      other_errors++;
      $display("ERROR: full never rose while the buffer was held");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+bench
common/lsq_pkg.sv
src/store_buffer.sv
src/store_issue.sv
src/store_lane_format.sv
src/store_drain.sv
bench/tb_clock.sv
bench/store_drain_tb.sv

// ==== Bender.yml ====
package:
  name: store_drain

sources:
  - files:
      - common/lsq_pkg.sv
      - src/store_buffer.sv
      - src/store_issue.sv
      - src/store_lane_format.sv
      - src/store_drain.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_clock.sv
      - bench/store_drain_tb.sv
